/* project.f */
hdl/cpu_pkg.sv
hdl/mem_req_if.sv
hdl/instruction_decoder.sv
hdl/register_file.sv
hdl/alu.sv
hdl/memory_port.sv
hdl/control_unit.sv
hdl/cpu_top.sv
dv/tb_memory.sv
dv/cpu_tb.sv

/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module cpu_tb -f project.f -o cpu_tb_sim
	out=$$(./obj_dir/cpu_tb_sim); echo "$$out"; echo "$$out" | grep -q "Test OK"

clean:
	rm -rf obj_dir

/* dv/cpu_tb.sv */
`timescale 1ns/100ps

module cpu_tb;

    localparam logic [6:0] OPI = 7'b0010011;
    localparam logic [6:0] LUI = 7'b0110111;
    localparam logic [6:0] AUIPC = 7'b0010111;
    localparam logic [6:0] LOAD = 7'b0000011;
    localparam logic [6:0] JALR = 7'b1100111;
    localparam cpu_pkg::word_t PRELOAD = 32'h8081_F2A3; // Data word at 0x300

    logic clock;
    logic reset;
    logic memory_enable;
    logic memory_operation;
    logic memory_ready;
    logic slow_ack;
    logic halted;
    cpu_pkg::word_t memory_address;
    cpu_pkg::word_t memory_data_in;
    cpu_pkg::word_t memory_data_out;
    cpu_pkg::mem_size_t memory_data_size;
    cpu_pkg::word_t halt_addr;
    cpu_pkg::word_t prog[$];
    cpu_pkg::word_t wr_addr[$];
    cpu_pkg::word_t wr_data[$];
    cpu_pkg::mem_size_t wr_size[$];
    cpu_pkg::word_t exp_addr[$];
    cpu_pkg::word_t exp_data[$];
    cpu_pkg::mem_size_t exp_size[$];
    int errors;
    int checks;
    int tests;

    cpu_top UUT (.clock, .reset, .memory_address, .memory_data_in, .memory_data_out,
                 .memory_data_size, .memory_enable, .memory_operation, .memory_ready);

    tb_memory memory (.clock, .reset, .address(memory_address), .write_data(memory_data_out),
                      .read_data(memory_data_in), .size(memory_data_size),
                      .enable(memory_enable), .operation(memory_operation),
                      .ready(memory_ready), .slow(slow_ack));

    always #2 clock = ~clock;

    // Bus monitor, one sample per completed transfer
    always @(posedge clock) begin
        if (!reset && memory_enable && memory_ready) begin
            if (memory_operation) begin
                wr_addr.push_back(memory_address);
                wr_size.push_back(memory_data_size);
                wr_data.push_back(memory_data_out);
            end else if (memory_address == halt_addr) begin
                halted <= 1'b1;
            end
        end
    end

    function automatic cpu_pkg::word_t i_type(int imm, int rs1, int f3, int rd, logic [6:0] opc);
        return {12'(imm), 5'(rs1), 3'(f3), 5'(rd), opc};
    endfunction

    function automatic cpu_pkg::word_t r_type(int f7, int rs2, int rs1, int f3, int rd);
        return {7'(f7), 5'(rs2), 5'(rs1), 3'(f3), 5'(rd), 7'b0110011};
    endfunction

    function automatic cpu_pkg::word_t s_type(int imm, int rs2, int rs1, int f3);
        cpu_pkg::word_t v;
        v = imm;
        return {v[11:5], 5'(rs2), 5'(rs1), 3'(f3), v[4:0], 7'b0100011};
    endfunction

    function automatic cpu_pkg::word_t b_type(int imm, int rs2, int rs1, int f3);
        cpu_pkg::word_t v;
        v = imm;
        return {v[12], v[10:5], 5'(rs2), 5'(rs1), 3'(f3), v[4:1], v[11], 7'b1100011};
    endfunction

    function automatic cpu_pkg::word_t u_type(int imm20, int rd, logic [6:0] opc);
        return {20'(imm20), 5'(rd), opc};
    endfunction

    function automatic cpu_pkg::word_t j_type(int imm, int rd);
        cpu_pkg::word_t v;
        v = imm;
        return {v[20], v[10:1], v[11], v[19:12], 5'(rd), 7'b1101111};
    endfunction

    function automatic logic branch_rule(int f3, cpu_pkg::word_t a, cpu_pkg::word_t b);
        case (f3)
            0:       return a == b;
            1:       return a != b;
            4:       return $signed(a) < $signed(b);
            5:       return $signed(a) >= $signed(b);
            6:       return a < b;
            default: return a >= b;
        endcase
    endfunction

    task automatic check_word(string name, cpu_pkg::word_t got, cpu_pkg::word_t expected);
        checks++;
        if (got !== expected) begin
            $display("Fail %s got %h expected %h", name, got, expected);
            errors++;
        end
    endtask

    task automatic check_size(string name, cpu_pkg::mem_size_t got,
                              cpu_pkg::mem_size_t expected);
        checks++;
        if (got !== expected) begin
            $display("Fail %s got %h expected %h", name, got, expected);
            errors++;
        end
    endtask

    task automatic put(cpu_pkg::word_t w);
        prog.push_back(w);
    endtask

    task automatic expect_write(cpu_pkg::word_t addr, cpu_pkg::mem_size_t size,
                                cpu_pkg::word_t data);
        exp_addr.push_back(addr);
        exp_size.push_back(size);
        exp_data.push_back(data);
    endtask

    // Store a register to the next result slot, data right aligned by size
    task automatic store_and_expect(int rs2, cpu_pkg::word_t value, cpu_pkg::mem_size_t size);
        cpu_pkg::word_t addr;
        addr = 32'h100 + 32'(4 * exp_addr.size());
        put(s_type(int'(addr), rs2, 0, int'(size)));
        case (size)
            cpu_pkg::SIZE_BYTE: expect_write(addr, size, {24'b0, value[7:0]});
            cpu_pkg::SIZE_HALF: expect_write(addr, size, {16'b0, value[15:0]});
            default:            expect_write(addr, size, value);
        endcase
    endtask

    task automatic alu_case(cpu_pkg::word_t instr, cpu_pkg::word_t expected);
        put(instr);
        store_and_expect(5, expected, cpu_pkg::SIZE_WORD);
    endtask

    task automatic load_case(int addr, int f3);
        cpu_pkg::word_t v;
        cpu_pkg::word_t e;
        v = PRELOAD >> (8 * (addr % 4));
        case (f3)
            0:       e = {{24{v[7]}}, v[7:0]};
            1:       e = {{16{v[15]}}, v[15:0]};
            4:       e = {24'b0, v[7:0]};
            5:       e = {16'b0, v[15:0]};
            default: e = v;
        endcase
        alu_case(i_type(addr, 0, f3, 5, LOAD), e);
    endtask

    task automatic build_alu_program();
        cpu_pkg::word_t a;
        cpu_pkg::word_t b;
        cpu_pkg::word_t c;
        a = 32'hFFFF_FFF9;
        b = 32'd3;
        c = 32'h8000_0000;
        prog.delete();
        exp_addr.delete();
        exp_size.delete();
        exp_data.delete();
        put(i_type(-7, 0, 0, 1, OPI));
        put(i_type(3, 0, 0, 2, OPI));
        put(u_type(32'h80000, 3, LUI));
        alu_case(r_type(0, 2, 1, 0, 5), a + b);
        alu_case(r_type(32, 2, 1, 0, 5), a - b);
        alu_case(r_type(0, 2, 1, 2, 5), {31'b0, $signed(a) < $signed(b)});
        alu_case(r_type(0, 2, 1, 3, 5), {31'b0, a < b});
        alu_case(r_type(0, 2, 2, 1, 5), b << b[4:0]);
        alu_case(r_type(0, 2, 1, 4, 5), a ^ b);
        alu_case(r_type(0, 3, 2, 6, 5), b | c);
        alu_case(r_type(0, 2, 1, 7, 5), a & b);
        alu_case(r_type(0, 2, 1, 5, 5), a >> 3);
        alu_case(r_type(32, 2, 3, 5, 5), $unsigned($signed(c) >>> 3));
        alu_case(i_type(-20, 1, 0, 5, OPI), a + 32'hFFFF_FFEC);
        alu_case(i_type(-8, 1, 2, 5, OPI), {31'b0, $signed(a) < -32'sd8});
        alu_case(i_type(-1, 1, 3, 5, OPI), {31'b0, a < 32'hFFFF_FFFF});
        alu_case(i_type(32'h55, 1, 4, 5, OPI), a ^ 32'h55);
        alu_case(i_type(32'h700, 2, 6, 5, OPI), b | 32'h700);
        alu_case(i_type(32'hF0, 1, 7, 5, OPI), a & 32'hF0);
        alu_case(i_type(4, 1, 1, 5, OPI), a << 4);
        alu_case(i_type(28, 1, 5, 5, OPI), a >> 28);
        alu_case(i_type(32'h404, 1, 5, 5, OPI), $unsigned($signed(a) >>> 4));
        put(i_type(5, 0, 0, 0, OPI));
        store_and_expect(0, 32'h0, cpu_pkg::SIZE_WORD); // x0 stays zero
    endtask

    task automatic run_program(string name, logic slow);
        int cycles;
        int start_errors;
        start_errors = errors;
        put(j_type(0, 0)); // Self-jump ends the program
        halt_addr = 32'(4 * (prog.size() - 1));
        foreach (prog[i]) begin
            for (int k = 0; k < 4; k++) memory.bytes[10'(4 * i + k)] = prog[i][8*k +: 8];
        end
        for (int k = 0; k < 4; k++) memory.bytes[10'(32'h300 + k)] = PRELOAD[8*k +: 8];
        wr_addr.delete();
        wr_size.delete();
        wr_data.delete();
        halted = 1'b0;
        @(posedge clock);
        slow_ack <= slow;
        reset <= 1'b1;
        repeat (5) begin
            @(posedge clock);
            if (memory_enable !== 1'b0) begin
                $display("%s: memory_enable was high during reset", name);
                errors++;
            end
        end
        reset <= 1'b0;
        cycles = 0;
        while (!halted && cycles < 5000) begin
            @(posedge clock);
            cycles++;
        end
        if (!halted) begin
            $display("%s: program never reached its final self-jump", name);
            errors++;
        end
        check_word("write count", 32'(wr_addr.size()), 32'(exp_addr.size()));
        foreach (exp_addr[i]) begin
            if (i < wr_addr.size()) begin
                check_word("memory_address", wr_addr[i], exp_addr[i]);
                check_size("memory_data_size", wr_size[i], exp_size[i]);
                check_word("memory_data_out", wr_data[i], exp_data[i]);
            end
        end
        tests++;
        $display("%s: %0d errors", name, errors - start_errors);
    endtask

    task automatic alu_operations();
        build_alu_program();
        run_program("alu", 1'b0);
    endtask

    task automatic upper_immediates();
        prog.delete();
        exp_addr.delete();
        exp_size.delete();
        exp_data.delete();
        alu_case(u_type(32'h12345, 5, LUI), 32'h1234_5000);
        alu_case(u_type(32'hABCDE, 5, AUIPC), 32'(4 * prog.size()) + 32'hABCD_E000);
        run_program("upper", 1'b0);
    endtask

    task automatic branch_conditions();
        int pair_a[3];
        int pair_b[3];
        int conds[6];
        cpu_pkg::word_t vals[2];
        int k;
        int p;
        pair_a = '{1, 2, 2};
        pair_b = '{2, 1, 2};
        conds = '{0, 1, 4, 5, 6, 7};
        vals = '{32'hFFFF_FFF9, 32'd3};
        prog.delete();
        exp_addr.delete();
        exp_size.delete();
        exp_data.delete();
        put(i_type(-7, 0, 0, 1, OPI));
        put(i_type(3, 0, 0, 2, OPI));
        put(i_type(32'h0A, 0, 0, 7, OPI)); // Not-taken marker
        put(i_type(32'h0B, 0, 0, 8, OPI)); // Taken marker
        k = 0;
        foreach (conds[c]) begin
            for (int j = 0; j < 3; j++) begin
                p = 32'h200 + 8 * k; // Above the program code
                put(b_type(12, pair_b[j], pair_a[j], conds[c]));
                put(s_type(p, 7, 0, 2));
                put(j_type(8, 0));
                put(s_type(p + 4, 8, 0, 2));
                if (branch_rule(conds[c], vals[pair_a[j] - 1], vals[pair_b[j] - 1]))
                    expect_write(32'(p + 4), cpu_pkg::SIZE_WORD, 32'h0B);
                else
                    expect_write(32'(p), cpu_pkg::SIZE_WORD, 32'h0A);
                k++;
            end
        end
        run_program("branch", 1'b0);
    endtask

    task automatic jumps_and_links();
        int q;
        prog.delete();
        exp_addr.delete();
        exp_size.delete();
        exp_data.delete();
        put(i_type(3, 0, 0, 2, OPI));
        q = 4 * prog.size();
        put(j_type(8, 9));
        put(s_type(32'h1F0, 2, 0, 2)); // Skipped by the jump
        store_and_expect(9, 32'(q + 4), cpu_pkg::SIZE_WORD);
        q = 4 * prog.size();
        put(i_type(q + 9, 0, 0, 10, OPI));
        put(i_type(4, 10, 0, 11, JALR)); // Odd target, bit 0 dropped
        put(s_type(32'h1F4, 2, 0, 2));
        store_and_expect(11, 32'(q + 8), cpu_pkg::SIZE_WORD);
        run_program("jump", 1'b0);
    endtask

    task automatic loads_and_stores();
        prog.delete();
        exp_addr.delete();
        exp_size.delete();
        exp_data.delete();
        put(i_type(-7, 0, 0, 1, OPI));
        load_case(32'h300, 0);
        load_case(32'h303, 0);
        load_case(32'h303, 4);
        load_case(32'h302, 1);
        load_case(32'h302, 5);
        load_case(32'h300, 1);
        load_case(32'h300, 2);
        store_and_expect(1, 32'hFFFF_FFF9, cpu_pkg::SIZE_BYTE);
        store_and_expect(1, 32'hFFFF_FFF9, cpu_pkg::SIZE_HALF);
        store_and_expect(1, 32'hFFFF_FFF9, cpu_pkg::SIZE_WORD);
        run_program("load store", 1'b0);
    endtask

    task automatic back_pressure();
        build_alu_program();
        run_program("back-pressure", 1'b1);
    endtask

    initial begin
        void'($urandom(32'hb924_99ba));
        clock = 1'b0;
        reset = 1'b1;
        slow_ack = 1'b0;
        halted = 1'b0;
        halt_addr = 32'hFFFF_FFFC;
        errors = 0;
        checks = 0;
        tests = 0;
        alu_operations();
        upper_immediates();
        branch_conditions();
        jumps_and_links();
        loads_and_stores();
        back_pressure();
        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

/* dv/tb_memory.sv */
`timescale 1ns/100ps

module tb_memory (
    input  logic               clock,
    input  logic               reset,
    input  cpu_pkg::word_t     address,
    input  cpu_pkg::word_t     write_data,
    output cpu_pkg::word_t     read_data,
    input  cpu_pkg::mem_size_t size,
    input  logic               enable,
    input  logic               operation,
    output logic               ready,
    input  logic               slow
);
    logic [7:0] bytes [0:1023]; // Byte addressed, wraps at 1 KiB
    int         waited;
    int         delay;

    initial begin
        delay     = 0;
        ready     = 1'b0;
        read_data = '0;
    end

    always @(posedge clock) begin
        int nbytes;
        nbytes = (size == cpu_pkg::SIZE_BYTE) ? 1 : (size == cpu_pkg::SIZE_HALF) ? 2 : 4;
        if (reset) begin
            ready  <= 1'b0;
            waited <= 0;
        end else if (enable && !ready) begin
            if (waited >= delay) begin
                ready  <= 1'b1;
                waited <= 0;
                if (operation) begin
                    for (int i = 0; i < 4; i++) begin
                        if (i < nbytes) bytes[10'(address + 32'(i))] <= write_data[8*i +: 8];
                    end
                end else begin
                    for (int i = 0; i < 4; i++) begin // Right aligned, upper bytes zero
                        read_data[8*i +: 8] <= (i < nbytes) ? bytes[10'(address + 32'(i))]
                                                            : 8'h00;
                    end
                end
            end else begin
                waited <= waited + 1;
            end
        end else if (!enable && ready) begin
            ready <= 1'b0;
            delay <= slow ? int'($urandom % 6) : 0;
        end
    end

endmodule

/* hdl/cpu_top.sv */
`timescale 1ns/100ps

module cpu_top #(
    parameter cpu_pkg::word_t RESET_ADDRESS = 32'h0
) (
    input  logic               clock,
    input  logic               reset,
    output cpu_pkg::word_t     memory_address,
    input  cpu_pkg::word_t     memory_data_in,
    output cpu_pkg::word_t     memory_data_out,
    output cpu_pkg::mem_size_t memory_data_size,
    output logic               memory_enable,
    output logic               memory_operation, // 1 means write
    input  logic               memory_ready
);
    cpu_pkg::word_t        instruction;
    cpu_pkg::reg_index_t   rs1;
    cpu_pkg::reg_index_t   rs2;
    cpu_pkg::reg_index_t   rd;
    cpu_pkg::word_t        immediate;
    cpu_pkg::instr_class_t instr_class;
    cpu_pkg::alu_op_t      alu_op;
    cpu_pkg::branch_cond_t branch_cond;
    cpu_pkg::mem_size_t    mem_size;
    logic                  load_unsigned;
    cpu_pkg::word_t        rs1_data;
    cpu_pkg::word_t        rs2_data;
    cpu_pkg::word_t        operand_b;
    cpu_pkg::word_t        alu_result;
    logic                  branch_taken;
    logic                  write_enable;
    cpu_pkg::word_t        rd_data;

    mem_req_if req ();

    control_unit #(.RESET_ADDRESS(RESET_ADDRESS)) u_control_unit (
        .clock, .reset, .mem(req.ctrl), .instruction, .instr_class, .immediate,
        .rs1_data, .rs2_data, .alu_result, .branch_taken, .operand_b,
        .write_enable, .rd_data, .mem_size, .load_unsigned
    );

    instruction_decoder u_instruction_decoder (
        .instruction, .rs1, .rs2, .rd, .immediate, .instr_class, .alu_op,
        .branch_cond, .mem_size, .load_unsigned
    );

    register_file u_register_file (
        .clock, .reset, .rs1, .rs2, .rs1_data, .rs2_data, .write_enable, .rd, .rd_data
    );

    alu u_alu (
        .alu_op, .operand_a(rs1_data), .operand_b, .result(alu_result),
        .branch_cond, .branch_taken
    );

    memory_port u_memory_port (
        .clock, .reset, .req(req.port), .memory_address, .memory_data_out,
        .memory_data_in, .memory_data_size, .memory_enable, .memory_operation, .memory_ready
    );

endmodule

/* hdl/control_unit.sv */
`timescale 1ns/100ps

module control_unit #(
    parameter cpu_pkg::word_t RESET_ADDRESS = 32'h0
) (
    input  logic                  clock,
    input  logic                  reset,
    mem_req_if.ctrl               mem,
    output cpu_pkg::word_t        instruction,
    input  cpu_pkg::instr_class_t instr_class,
    input  cpu_pkg::word_t        immediate,
    input  cpu_pkg::word_t        rs1_data,
    input  cpu_pkg::word_t        rs2_data,
    input  cpu_pkg::word_t        alu_result,
    input  logic                  branch_taken,
    output cpu_pkg::word_t        operand_b,
    output logic                  write_enable,
    output cpu_pkg::word_t        rd_data,
    input  cpu_pkg::mem_size_t    mem_size,
    input  logic                  load_unsigned
);
    typedef enum logic [1:0] {STAGE_FETCH, STAGE_EXECUTE, STAGE_MEMORY} stage_t;

    stage_t         stage;
    logic           pending;   // Request issued, waiting for done
    logic           is_mem_op;
    logic           writes_rd;
    cpu_pkg::word_t pc;
    cpu_pkg::word_t pc_plus_4;
    cpu_pkg::word_t pc_plus_imm;
    cpu_pkg::word_t effective_address;
    cpu_pkg::word_t next_pc;

    assign pc_plus_4         = pc + cpu_pkg::INSTR_BYTES;
    assign pc_plus_imm       = pc + immediate;
    assign effective_address = rs1_data + immediate;
    assign is_mem_op = (instr_class == cpu_pkg::CLASS_LOAD || instr_class == cpu_pkg::CLASS_STORE);
    assign writes_rd = !(instr_class inside {cpu_pkg::CLASS_BRANCH, cpu_pkg::CLASS_SKIP})
                       && !is_mem_op;

    assign operand_b = (instr_class == cpu_pkg::CLASS_ALU_REG ||
                        instr_class == cpu_pkg::CLASS_BRANCH) ? rs2_data : immediate;

    assign mem.start         = (stage != STAGE_EXECUTE) && !pending;
    assign mem.write         = (stage == STAGE_MEMORY) && (instr_class == cpu_pkg::CLASS_STORE);
    assign mem.address       = (stage == STAGE_FETCH) ? pc : effective_address;
    assign mem.size          = (stage == STAGE_FETCH) ? cpu_pkg::SIZE_WORD : mem_size;
    assign mem.store_data    = rs2_data;
    assign mem.load_unsigned = load_unsigned;

    assign write_enable = (stage == STAGE_EXECUTE && writes_rd) ||
                          (stage == STAGE_MEMORY && instr_class == cpu_pkg::CLASS_LOAD && mem.done);

    always_comb begin
        case (instr_class)
            cpu_pkg::CLASS_ALU_REG, cpu_pkg::CLASS_ALU_IMM: rd_data = alu_result;
            cpu_pkg::CLASS_LUI:   rd_data = immediate;
            cpu_pkg::CLASS_AUIPC: rd_data = pc_plus_imm;
            cpu_pkg::CLASS_LOAD:  rd_data = mem.load_data;
            default:              rd_data = pc_plus_4; // Link address
        endcase
    end

    always_comb begin
        case (instr_class)
            cpu_pkg::CLASS_BRANCH: next_pc = branch_taken ? pc_plus_imm : pc_plus_4;
            cpu_pkg::CLASS_JAL:    next_pc = pc_plus_imm;
            cpu_pkg::CLASS_JALR:   next_pc = {effective_address[31:1], 1'b0};
            default:               next_pc = pc_plus_4;
        endcase
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            stage   <= STAGE_FETCH;
            pending <= 1'b0;
            pc      <= RESET_ADDRESS;
        end else begin
            case (stage)
                STAGE_EXECUTE: begin
                    if (is_mem_op) begin
                        stage <= STAGE_MEMORY;
                    end else begin
                        pc    <= next_pc;
                        stage <= STAGE_FETCH;
                    end
                end
                default: begin // Fetch or memory request in flight
                    if (mem.start) pending <= 1'b1;
                    if (mem.done) begin
                        pending <= 1'b0;
                        if (stage == STAGE_FETCH) begin
                            stage <= STAGE_EXECUTE;
                        end else begin
                            pc    <= next_pc;
                            stage <= STAGE_FETCH;
                        end
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (stage == STAGE_FETCH && mem.done) instruction <= mem.load_data;
    end

    start_in_request_stage: assert property (@(posedge clock) disable iff (reset)
        mem.start |-> stage == STAGE_FETCH || (stage == STAGE_MEMORY && is_mem_op));

endmodule

/* hdl/memory_port.sv */
`timescale 1ns/100ps

module memory_port (
    input  logic               clock,
    input  logic               reset,
    mem_req_if.port            req,
    output cpu_pkg::word_t     memory_address,
    output cpu_pkg::word_t     memory_data_out,
    input  cpu_pkg::word_t     memory_data_in,
    output cpu_pkg::mem_size_t memory_data_size,
    output logic               memory_enable,
    output logic               memory_operation,
    input  logic               memory_ready
);
    typedef enum logic [1:0] {PORT_IDLE, PORT_REQUEST, PORT_WAIT_ACK} port_state_t;

    port_state_t state;
    logic        load_unsigned;

    assign req.done = (state == PORT_WAIT_ACK) && memory_ready;

    always_comb begin
        case (memory_data_size)
            cpu_pkg::SIZE_BYTE: req.load_data = {{24{!load_unsigned && memory_data_in[7]}},
                                                 memory_data_in[7:0]};
            cpu_pkg::SIZE_HALF: req.load_data = {{16{!load_unsigned && memory_data_in[15]}},
                                                 memory_data_in[15:0]};
            default:            req.load_data = memory_data_in;
        endcase
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state         <= PORT_IDLE;
            memory_enable <= 1'b0;
        end else begin
            case (state)
                PORT_IDLE: if (req.start) state <= PORT_REQUEST;
                PORT_REQUEST: begin
                    if (!memory_ready) begin // Previous acknowledge has cleared
                        memory_enable <= 1'b1;
                        state         <= PORT_WAIT_ACK;
                    end
                end
                default: begin
                    if (memory_ready) begin
                        memory_enable <= 1'b0;
                        state         <= PORT_IDLE;
                    end
                end
            endcase
        end
    end

    // Request fields held from start until done
    always_ff @(posedge clock) begin
        if (state == PORT_IDLE && req.start) begin
            memory_address   <= req.address;
            memory_operation <= req.write;
            memory_data_size <= req.size;
            load_unsigned    <= req.load_unsigned;
            case (req.size)
                cpu_pkg::SIZE_BYTE: memory_data_out <= {24'b0, req.store_data[7:0]};
                cpu_pkg::SIZE_HALF: memory_data_out <= {16'b0, req.store_data[15:0]};
                default:            memory_data_out <= req.store_data;
            endcase
        end
    end

    enable_after_ready_low: assert property (@(posedge clock) disable iff (reset)
        $rose(memory_enable) |-> $past(!memory_ready));

    address_stable: assert property (@(posedge clock) disable iff (reset)
        memory_enable && $past(memory_enable) |-> $stable(memory_address));

endmodule

/* hdl/alu.sv */
`timescale 1ns/100ps

module alu (
    input  cpu_pkg::alu_op_t      alu_op,
    input  cpu_pkg::word_t        operand_a,
    input  cpu_pkg::word_t        operand_b,
    output cpu_pkg::word_t        result,
    input  cpu_pkg::branch_cond_t branch_cond,
    output logic                  branch_taken
);
    logic [4:0] shift_amount;
    logic       equal;
    logic       less_signed;
    logic       less_unsigned;

    assign shift_amount  = operand_b[4:0];
    assign equal         = (operand_a == operand_b);
    assign less_signed   = ($signed(operand_a) < $signed(operand_b));
    assign less_unsigned = (operand_a < operand_b);

    always_comb begin
        case (alu_op)
            cpu_pkg::ALU_ADD:  result = operand_a + operand_b;
            cpu_pkg::ALU_SUB:  result = operand_a - operand_b;
            cpu_pkg::ALU_SLT:  result = {31'b0, less_signed};
            cpu_pkg::ALU_SLTU: result = {31'b0, less_unsigned};
            cpu_pkg::ALU_XOR:  result = operand_a ^ operand_b;
            cpu_pkg::ALU_OR:   result = operand_a | operand_b;
            cpu_pkg::ALU_AND:  result = operand_a & operand_b;
            cpu_pkg::ALU_SLL:  result = operand_a << shift_amount;
            cpu_pkg::ALU_SRL:  result = operand_a >> shift_amount;
            cpu_pkg::ALU_SRA:  result = $unsigned($signed(operand_a) >>> shift_amount);
            default:           result = operand_a + operand_b;
        endcase
    end

    always_comb begin
        case (branch_cond)
            cpu_pkg::BR_EQ:  branch_taken = equal;
            cpu_pkg::BR_NE:  branch_taken = !equal;
            cpu_pkg::BR_LT:  branch_taken = less_signed;
            cpu_pkg::BR_GE:  branch_taken = !less_signed;
            cpu_pkg::BR_LTU: branch_taken = less_unsigned;
            cpu_pkg::BR_GEU: branch_taken = !less_unsigned;
            default:         branch_taken = 1'b0;
        endcase
    end

endmodule

/* hdl/register_file.sv */
`timescale 1ns/100ps

module register_file (
    input  logic                clock,
    input  logic                reset,
    input  cpu_pkg::reg_index_t rs1,
    input  cpu_pkg::reg_index_t rs2,
    output cpu_pkg::word_t      rs1_data,
    output cpu_pkg::word_t      rs2_data,
    input  logic                write_enable,
    input  cpu_pkg::reg_index_t rd,
    input  cpu_pkg::word_t      rd_data
);
    cpu_pkg::word_t registers [1:31]; // x0 is not stored

    assign rs1_data = (rs1 == '0) ? '0 : registers[rs1];
    assign rs2_data = (rs2 == '0) ? '0 : registers[rs2];

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            for (int i = 1; i < 32; i++) begin
                registers[i] <= '0;
            end
        end else if (write_enable && rd != '0) begin
            registers[rd] <= rd_data;
        end
    end

    writeback_known: assert property (@(posedge clock) disable iff (reset)
        write_enable |-> !$isunknown(rd_data));

endmodule

/* hdl/instruction_decoder.sv */
`timescale 1ns/100ps

module instruction_decoder (
    input  cpu_pkg::word_t        instruction,
    output cpu_pkg::reg_index_t   rs1,
    output cpu_pkg::reg_index_t   rs2,
    output cpu_pkg::reg_index_t   rd,
    output cpu_pkg::word_t        immediate,
    output cpu_pkg::instr_class_t instr_class,
    output cpu_pkg::alu_op_t      alu_op,
    output cpu_pkg::branch_cond_t branch_cond,
    output cpu_pkg::mem_size_t    mem_size,
    output logic                  load_unsigned
);
    cpu_pkg::opcode_t opcode;
    logic [2:0]       funct3;

    assign opcode        = cpu_pkg::opcode_t'(instruction[6:2]);
    assign funct3        = instruction[14:12];
    assign rs1           = instruction[19:15];
    assign rs2           = instruction[24:20];
    assign rd            = instruction[11:7];
    assign mem_size      = cpu_pkg::mem_size_t'(funct3[1:0]);
    assign load_unsigned = funct3[2];
    assign branch_cond   = cpu_pkg::branch_cond_t'(funct3);

    always_comb begin
        instr_class = cpu_pkg::CLASS_SKIP;
        immediate   = {{20{instruction[31]}}, instruction[31:20]}; // I format
        if (instruction[1:0] == 2'b11) begin
            case (opcode)
                cpu_pkg::OPC_OP_IMM: instr_class = cpu_pkg::CLASS_ALU_IMM;
                cpu_pkg::OPC_OP:     instr_class = cpu_pkg::CLASS_ALU_REG;
                cpu_pkg::OPC_JALR:   instr_class = cpu_pkg::CLASS_JALR;
                cpu_pkg::OPC_LUI, cpu_pkg::OPC_AUIPC: begin
                    instr_class = (opcode == cpu_pkg::OPC_LUI) ? cpu_pkg::CLASS_LUI
                                                                : cpu_pkg::CLASS_AUIPC;
                    immediate = {instruction[31:12], 12'b0};
                end
                cpu_pkg::OPC_JAL: begin
                    instr_class = cpu_pkg::CLASS_JAL;
                    immediate = {{12{instruction[31]}}, instruction[19:12], instruction[20],
                                 instruction[30:21], 1'b0};
                end
                cpu_pkg::OPC_BRANCH: begin
                    if (funct3[2:1] != 2'b01) instr_class = cpu_pkg::CLASS_BRANCH;
                    immediate = {{20{instruction[31]}}, instruction[7], instruction[30:25],
                                 instruction[11:8], 1'b0};
                end
                cpu_pkg::OPC_LOAD: begin
                    if (funct3[1:0] != 2'b11 && funct3 != 3'b110) begin // LB LH LW LBU LHU
                        instr_class = cpu_pkg::CLASS_LOAD;
                    end
                end
                cpu_pkg::OPC_STORE: begin
                    if (!funct3[2] && funct3[1:0] != 2'b11) instr_class = cpu_pkg::CLASS_STORE;
                    immediate = {{20{instruction[31]}}, instruction[31:25], instruction[11:7]};
                end
                default: ;
            endcase
        end
    end

    always_comb begin
        case (funct3)
            3'b000:  alu_op = (opcode == cpu_pkg::OPC_OP && instruction[30]) ? cpu_pkg::ALU_SUB
                                                                              : cpu_pkg::ALU_ADD;
            3'b001:  alu_op = cpu_pkg::ALU_SLL;
            3'b010:  alu_op = cpu_pkg::ALU_SLT;
            3'b011:  alu_op = cpu_pkg::ALU_SLTU;
            3'b100:  alu_op = cpu_pkg::ALU_XOR;
            3'b101:  alu_op = instruction[30] ? cpu_pkg::ALU_SRA : cpu_pkg::ALU_SRL;
            3'b110:  alu_op = cpu_pkg::ALU_OR;
            default: alu_op = cpu_pkg::ALU_AND;
        endcase
    end

endmodule

/* hdl/mem_req_if.sv */
`timescale 1ns/100ps

interface mem_req_if;

    logic               start;
    logic               write;
    cpu_pkg::word_t     address;
    cpu_pkg::mem_size_t size;
    cpu_pkg::word_t     store_data;
    logic               load_unsigned; // Extension rule for load_data
    logic               done;
    cpu_pkg::word_t     load_data;

    modport ctrl (
        output start, write, address, size, store_data, load_unsigned,
        input  done, load_data
    );

    modport port (
        input  start, write, address, size, store_data, load_unsigned,
        output done, load_data
    );

endinterface

/* hdl/cpu_pkg.sv */
package cpu_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_index_t;

    typedef enum logic [1:0] {
        SIZE_BYTE = 2'd0,
        SIZE_HALF = 2'd1,
        SIZE_WORD = 2'd2
    } mem_size_t;

    // Bits 6:2 of the instruction, low two bits are always 11
    typedef enum logic [4:0] {
        OPC_LOAD   = 5'b00000,
        OPC_OP_IMM = 5'b00100,
        OPC_AUIPC  = 5'b00101,
        OPC_STORE  = 5'b01000,
        OPC_OP     = 5'b01100,
        OPC_LUI    = 5'b01101,
        OPC_BRANCH = 5'b11000,
        OPC_JALR   = 5'b11001,
        OPC_JAL    = 5'b11011
    } opcode_t;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLT, ALU_SLTU, ALU_XOR,
        ALU_OR, ALU_AND, ALU_SLL, ALU_SRL, ALU_SRA
    } alu_op_t;

    // Encoded as funct3 of the branch instructions
    typedef enum logic [2:0] {
        BR_EQ  = 3'b000,
        BR_NE  = 3'b001,
        BR_LT  = 3'b100,
        BR_GE  = 3'b101,
        BR_LTU = 3'b110,
        BR_GEU = 3'b111
    } branch_cond_t;

    typedef enum logic [3:0] {
        CLASS_ALU_REG, CLASS_ALU_IMM, CLASS_LUI, CLASS_AUIPC, CLASS_BRANCH,
        CLASS_JAL, CLASS_JALR, CLASS_LOAD, CLASS_STORE, CLASS_SKIP
    } instr_class_t;

    localparam word_t INSTR_BYTES = 32'd4;

endpackage
